// ==== button_debounce.sv ====
// switch debouncer
// output follows the input once it has been stable for a settle period
`default_nettype none

module button_debounce #(
   parameter int SETTLE_COUNT = 16
) (
   input  logic clock,
   input  logic reset,
   input  logic noisy,
   output logic clean
);

   // counter must hold the value SETTLE_COUNT
   localparam int count_width = (SETTLE_COUNT > 0) ? $clog2(SETTLE_COUNT + 1) : 1;

   logic [count_width-1:0] count;
   // last value seen on the input
   logic                   sampled;

   always_ff @(posedge clock) begin
      if (reset) begin
         // start out agreeing with the pin, no settle wait
         sampled <= noisy;
         clean   <= noisy;
         count   <= '0;
      end else if (noisy != sampled) begin
         // any edge restarts the settle period
         sampled <= noisy;
         count   <= '0;
      end else if (count == count_width'(SETTLE_COUNT)) begin
         // stable long enough, pass it through
         // count stays parked here until the next edge
         clean <= sampled;
      end else begin
         count <= count + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== display_mode_ctrl.sv ====
// display mode controller
// holds a new mode request until the frame ends so no frame is torn
`default_nettype none

module display_mode_ctrl (
   input  logic                          clock,
   input  logic                          reset,
   input  video_pixel_pkg::display_mode_t mode_request,
   input  logic                          frame_end,
   output video_pixel_pkg::display_mode_t mode
);

   import video_pixel_pkg::*;

   ctrl_state_t state;

   ////////////////////////////////////////////////////////////////////////////
   // two state FSM
   //
   // state_run      mode matches the request, nothing to do
   // state_pending  request differs, wait for the frame boundary
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         state <= state_run;
         mode  <= mode_notes;
      end else begin
         case (state)
            state_run: begin
               // new request from the debounced switches
               if (mode_request != mode) begin
                  state <= state_pending;
               end
            end

            state_pending: begin
               // take whatever the switches say at the boundary,
               // even if they went back to the current mode
               if (frame_end) begin
                  mode  <= mode_request;
                  state <= state_run;
               end
            end

            default: begin
               state <= state_run;
            end
         endcase
      end
   end

   // mode moves on the cycle after frame_end, i.e. on the
   // first pixel of the new frame

endmodule

`default_nettype wire

// ==== note_renderer.sv ====
// note display source
// tests the raster position against three fixed rectangles
// and registers the resulting colour
`default_nettype none

module note_renderer (
   input  logic                         clock,
   input  logic                         reset,
   input  video_timing_pkg::pixel_pos_t pos,
   output video_pixel_pkg::rgb_t        note_pixel
);

   import video_timing_pkg::*;
   import video_pixel_pkg::*;

   // rectangle hit flags for the current position
   logic in_a;
   logic in_b;
   logic in_c;
   rgb_t note_mix;

   // inside means x <= h < x + w and y <= v < y + h
   function automatic logic in_rect(
      input pixel_pos_t p,
      input int         x,
      input int         y,
      input int         w,
      input int         h
   );
      logic in_h;
      logic in_v;
      in_h = (int'(p.hcount) >= x) && (int'(p.hcount) < x + w);
      in_v = (int'(p.vcount) >= y) && (int'(p.vcount) < y + h);
      return in_h && in_v;
   endfunction

   always_comb begin
      in_a = in_rect(pos, note_a_x, note_a_y, note_a_w, note_a_h);
      in_b = in_rect(pos, note_b_x, note_b_y, note_b_w, note_b_h);
      in_c = in_rect(pos, note_c_x, note_c_y, note_c_w, note_c_h);

      // overlapping notes simply OR together
      note_mix = ({24{in_a}} & note_colour)
               | ({24{in_b}} & note_colour)
               | ({24{in_c}} & note_colour);
   end

   // one cycle from pos to note_pixel
   always_ff @(posedge clock) begin
      if (reset) begin
         note_pixel <= '0;
      end else begin
         note_pixel <= note_mix;
      end
   end

endmodule

`default_nettype wire

// ==== pattern_generator.sv ====
// border and colour bar sources
// mode select between notes, border and bars
// output pixel and sync register
`default_nettype none

module pattern_generator (
   input  logic                          clock,
   input  logic                          reset,
   input  video_timing_pkg::pixel_pos_t  pos,
   input  video_timing_pkg::video_sync_t sync,
   input  video_pixel_pkg::rgb_t         note_pixel,
   input  video_pixel_pkg::display_mode_t mode,
   output video_pixel_pkg::rgb_t         pixel,
   output video_timing_pkg::video_sync_t sync_out
);

   import video_timing_pkg::*;
   import video_pixel_pkg::*;

   // stage 1, aligned with note_pixel
   pixel_pos_t    pos_d;
   video_sync_t   sync_d;
   display_mode_t mode_d;

   logic on_border;
   rgb_t border_pixel;
   rgb_t bar_pixel;
   rgb_t selected;

   ////////////////////////////////////////////////////////////////////////////
   // stage 1 delay
   // mode travels with pos so a frame never mixes two modes
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clock) begin
      pos_d <= pos;
      if (reset) begin
         sync_d <= '{hsync: 1'b1, vsync: 1'b1, blank: 1'b0};
         mode_d <= mode_notes;
      end else begin
         sync_d <= sync;
         mode_d <= mode;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // pixel sources and select
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      // one pixel outline of the visible area
      on_border = (pos_d.hcount == 11'd0) || (pos_d.hcount == h_active - 1'b1)
               || (pos_d.vcount == 10'd0) || (pos_d.vcount == v_active - 1'b1);
      border_pixel = {24{on_border}};

      // eight bars, 256 pixels wide per red step
      bar_pixel.red   = {8{pos_d.hcount[8]}};
      bar_pixel.green = {8{pos_d.hcount[7]}};
      bar_pixel.blue  = {8{pos_d.hcount[6]}};

      case (mode_d)
         mode_border: selected = border_pixel;
         mode_bars:   selected = bar_pixel;
         // notes, and the unused code 2'b11
         default:     selected = note_pixel;
      endcase
   end

   // stage 2, two cycles after pos and sync
   always_ff @(posedge clock) begin
      if (reset) begin
         pixel    <= '0;
         sync_out <= '{hsync: 1'b1, vsync: 1'b1, blank: 1'b0};
      end else begin
         pixel    <= selected;
         sync_out <= sync_d;
      end
   end

endmodule

`default_nettype wire

// ==== tb_video_test.sv ====
// testbench for the XVGA test pattern generator
// clock and reset, LFSR driven bouncing mode switch, frame waits
`default_nettype none

module tb_video_test;

   timeunit 1ns;
   timeprecision 1ps;

   import video_timing_pkg::*;
   import video_pixel_pkg::*;

   localparam int settle_count  = 16;
   localparam int half_period   = 4;
   // one full XVGA frame plus some slack
   localparam int frame_timeout = 1344 * 806 + 1000;

   logic          clock;
   logic          reset;
   logic [1:0]    mode_switch;
   rgb_t          pixel;
   video_sync_t   sync;
   display_mode_t mode_led;
   logic [31:0]   lfsr;

   video_test_top #(
      .SETTLE_COUNT (settle_count)
   ) u_dut (
      .clock       (clock),
      .reset       (reset),
      .mode_switch (mode_switch),
      .pixel       (pixel),
      .sync        (sync),
      .mode_led    (mode_led)
   );

   bind video_test_top video_test_checker #(
      .SETTLE_COUNT (SETTLE_COUNT)
   ) u_checker (
      .clock       (clock),
      .reset       (reset),
      .mode_switch (mode_switch),
      .pixel       (pixel),
      .sync        (sync),
      .mode_led    (mode_led)
   );

   initial begin
      clock = 1'b0;
      forever #(half_period) clock = ~clock;
   end

   ////////////////////////////////////////////////////////////////////////////
   // random bits
   ////////////////////////////////////////////////////////////////////////////

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++) begin
         value = (value << 1) | lfsr[0];
         lfsr  = lfsr_next(lfsr);
      end
   endtask

   // returns on the clock edge that starts the next frame
   task automatic wait_frame_start();
      int cycles;
      cycles = 0;
      @(negedge clock);
      while (!u_dut.frame_end && (cycles < frame_timeout)) begin
         @(negedge clock);
         cycles++;
      end
      if (!u_dut.frame_end) begin
         $display("Finished with errors");
         $fatal(1, "timeout: no frame start within %0d cycles", frame_timeout);
      end else begin
         @(posedge clock);
      end
   endtask

   // mid frame switch change with a burst of contact bounce
   task automatic change_mode(input logic [1:0] target);
      logic [1:0] previous;
      int         lines;
      int         toggles;
      int         hold;
      previous = mode_switch;
      draw_bits(8, lines);
      repeat ((lines + 100) * 1344) @(posedge clock);
      draw_bits(2, toggles);
      for (int i = 0; i < toggles + 2; i++) begin
         mode_switch <= (i % 2 == 0) ? target : previous;
         draw_bits(3, hold);
         repeat (hold + 1) @(posedge clock);
      end
      mode_switch <= target;
      // settle, then the new mode by the second frame start
      wait_frame_start();
      wait_frame_start();
   endtask

   // any failed assertion ends the run
   always @(negedge clock) begin
      if (u_dut.u_checker.error_count != 0) begin
         $display("Finished with errors");
         $fatal(1, "checker assertion failed");
      end
   end

   initial begin
      reset       = 1'b1;
      mode_switch = 2'b00;
      lfsr        = 32'h9c65;
      repeat (4) @(posedge clock);
      reset <= 1'b0;
      change_mode(mode_border);
      change_mode(mode_bars);
      change_mode(mode_notes);
      repeat (16) @(posedge clock);
      if (u_dut.u_checker.error_count != 0) begin
         $display("Finished with errors");
         $fatal(1, "checker assertion failed");
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== video_pixel_pkg.sv ====
// colour channel and rgb pixel types
// display mode encoding and mode controller FSM states
// note rectangle positions, sizes and colour
`default_nettype none

package video_pixel_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // pixel colour
   ////////////////////////////////////////////////////////////////////////////

   // one 8-bit channel
   typedef logic [7:0] colour_t;

   typedef struct packed {
      colour_t red;
      colour_t green;
      colour_t blue;
   } rgb_t;

   ////////////////////////////////////////////////////////////////////////////
   // mode selection
   ////////////////////////////////////////////////////////////////////////////

   // 2'b11 is not named, it falls back to the note display
   typedef enum logic [1:0] {
      mode_notes  = 2'b00,
      mode_border = 2'b01,
      mode_bars   = 2'b10
   } display_mode_t;

   // mode controller states
   typedef enum logic {
      state_run     = 1'b0,
      state_pending = 1'b1
   } ctrl_state_t;

   ////////////////////////////////////////////////////////////////////////////
   // note rectangles, top left corner plus size
   ////////////////////////////////////////////////////////////////////////////
   localparam int note_a_x = 500;
   localparam int note_a_y = 500;
   localparam int note_a_w = 64;
   localparam int note_a_h = 24;

   localparam int note_b_x = 300;
   localparam int note_b_y = 300;
   localparam int note_b_w = 64;
   localparam int note_b_h = 40;

   localparam int note_c_x = 100;
   localparam int note_c_y = 100;
   localparam int note_c_w = 64;
   localparam int note_c_h = 64;

   // all three notes are drawn in white
   localparam rgb_t note_colour = '{red: 8'hff, green: 8'hff, blue: 8'hff};

endpackage

`default_nettype wire

// ==== video_test.f ====
video_timing_pkg.sv
video_pixel_pkg.sv
button_debounce.sv
xvga_timing.sv
display_mode_ctrl.sv
note_renderer.sv
pattern_generator.sv
video_test_top.sv
video_test_checker.sv
tb_video_test.sv

// ==== video_test_checker.sv ====
// bound checker for the XVGA test pattern generator
// raster model with expected sync and pixel two cycles later
// mode switch timing against frame boundaries
`default_nettype none

module video_test_checker #(
   parameter int SETTLE_COUNT = 16
) (
   input  logic                           clock,
   input  logic                           reset,
   input  logic [1:0]                     mode_switch,
   input  video_pixel_pkg::rgb_t          pixel,
   input  video_timing_pkg::video_sync_t  sync,
   input  video_pixel_pkg::display_mode_t mode_led
);

   timeunit 1ns;
   timeprecision 1ps;

   import video_timing_pkg::*;
   import video_pixel_pkg::*;

   // failure count read by the testbench
   int            error_count = 0;
   // modelled raster position that tracks the DUT counters
   h_count_t      m_h;
   v_count_t      m_v;
   // position and mode one and two cycles back
   pixel_pos_t    p1;
   pixel_pos_t    p2;
   display_mode_t mo1;
   display_mode_t mo2;
   logic          last_pixel;
   logic [1:0]    switch_prev;
   int            stable_cycles;
   int            starts_seen;
   logic          settled;

   // sync and blank rule for one raster position
   function automatic video_sync_t expected_sync(input pixel_pos_t p);
      video_sync_t s;
      s.hsync = !((p.hcount >= 1048) && (p.hcount < 1184));
      s.vsync = !((p.vcount >= 777) && (p.vcount < 783));
      s.blank = (p.hcount >= 1024) || (p.vcount >= 768);
      return s;
   endfunction

   // white inside any of the three notes
   function automatic rgb_t expected_notes(input pixel_pos_t p);
      int   h;
      int   v;
      logic hit;
      h = p.hcount;
      v = p.vcount;
      hit = (h >= 500 && h < 564 && v >= 500 && v < 524)
         || (h >= 300 && h < 364 && v >= 300 && v < 340)
         || (h >= 100 && h < 164 && v >= 100 && v < 164);
      return {24{hit}};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // raster model and alignment pipeline
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         m_h <= '0;
         m_v <= '0;
      end else begin
         m_h <= (m_h == 11'd1343) ? '0 : m_h + 1'b1;
         if (m_h == 11'd1343) begin
            m_v <= (m_v == 10'd805) ? '0 : m_v + 1'b1;
         end
      end
      p1  <= '{hcount: m_h, vcount: m_v};
      p2  <= p1;
      mo1 <= mode_led;
      mo2 <= mo1;
   end

   assign last_pixel = (m_h == 11'd1343) && (m_v == 10'd805);
   // a fresh switch edge drops settled at once, before the count restarts
   assign settled    = (stable_cycles > SETTLE_COUNT + 1) && (mode_switch == switch_prev);

   // switch stability and frame starts seen since it settled
   always_ff @(posedge clock) begin
      switch_prev <= mode_switch;
      if (reset || (mode_switch != switch_prev)) begin
         stable_cycles <= 0;
         starts_seen   <= 0;
      end else begin
         if (stable_cycles <= SETTLE_COUNT + 1) begin
            stable_cycles <= stable_cycles + 1;
         end
         if (settled && (m_h == '0) && (m_v == '0) && (starts_seen < 2)) begin
            starts_seen <= starts_seen + 1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // assertions
   ////////////////////////////////////////////////////////////////////////////
   a_idle_after_reset: assert property (@(posedge clock) disable iff (reset)
      $fell(reset) |-> (pixel == '0) && (sync == 3'b110))
      else begin
         $error("ERROR %0t: outputs not idle right after reset", $time);
         error_count++;
      end

   a_sync: assert property (@(posedge clock) disable iff (reset)
      sync == expected_sync(p2))
      else begin
         $error("ERROR %0t: sync %b at h %0d v %0d", $time, sync, p2.hcount, p2.vcount);
         error_count++;
      end

   // code 2'b11 draws the notes as well
   a_notes: assert property (@(posedge clock) disable iff (reset)
      (mo2 != mode_border) && (mo2 != mode_bars) |-> pixel == expected_notes(p2))
      else begin
         $error("ERROR %0t: note pixel %h at h %0d v %0d", $time, pixel, p2.hcount, p2.vcount);
         error_count++;
      end

   a_border: assert property (@(posedge clock) disable iff (reset)
      (mo2 == mode_border) |-> pixel == {24{(p2.hcount == 0) || (p2.hcount == 1023)
                                           || (p2.vcount == 0) || (p2.vcount == 767)}})
      else begin
         $error("ERROR %0t: border pixel %h at h %0d v %0d", $time, pixel, p2.hcount, p2.vcount);
         error_count++;
      end

   a_bars: assert property (@(posedge clock) disable iff (reset)
      (mo2 == mode_bars) |-> pixel == {{8{p2.hcount[8]}}, {8{p2.hcount[7]}}, {8{p2.hcount[6]}}})
      else begin
         $error("ERROR %0t: bar pixel %h at h %0d", $time, pixel, p2.hcount);
         error_count++;
      end

   // a mode change lands only on the first pixel of a frame
   a_mode_boundary: assert property (@(posedge clock) disable iff (reset)
      !$stable(mode_led) |-> $past(last_pixel))
      else begin
         $error("ERROR %0t: mode_led changed to %0d mid frame", $time, mode_led);
         error_count++;
      end

   a_mode_follows: assert property (@(posedge clock) disable iff (reset)
      settled && (starts_seen >= 2) |-> (2'(mode_led) == mode_switch))
      else begin
         $error("ERROR %0t: mode_led %0d, switch %0d", $time, mode_led, mode_switch);
         error_count++;
      end

endmodule

`default_nettype wire

// ==== video_test_top.sv ====
// XVGA test pattern generator top level
// switch debouncers, raster timing, mode controller and pixel datapath
`default_nettype none

module video_test_top #(
   parameter int SETTLE_COUNT = 16
) (
   input  logic                           clock,
   input  logic                           reset,
   input  logic [1:0]                     mode_switch,
   output video_pixel_pkg::rgb_t          pixel,
   output video_timing_pkg::video_sync_t  sync,
   output video_pixel_pkg::display_mode_t mode_led
);

   import video_timing_pkg::*;
   import video_pixel_pkg::*;

   logic [1:0]    debounced;
   display_mode_t mode_request;
   pixel_pos_t    pos;
   video_sync_t   raw_sync;
   logic          frame_end;
   rgb_t          note_pixel;

   ////////////////////////////////////////////////////////////////////////////
   // mode switches
   ////////////////////////////////////////////////////////////////////////////
   for (genvar i = 0; i < 2; i++) begin : g_debounce
      button_debounce #(
         .SETTLE_COUNT (SETTLE_COUNT)
      ) u_debounce (
         .clock (clock),
         .reset (reset),
         .noisy (mode_switch[i]),
         .clean (debounced[i])
      );
   end

   // switch code maps straight onto the mode encoding
   assign mode_request = display_mode_t'(debounced);

   display_mode_ctrl u_mode_ctrl (
      .clock        (clock),
      .reset        (reset),
      .mode_request (mode_request),
      .frame_end    (frame_end),
      .mode         (mode_led)
   );

   ////////////////////////////////////////////////////////////////////////////
   // video datapath, pixel and sync two cycles behind the counters
   ////////////////////////////////////////////////////////////////////////////
   xvga_timing u_timing (
      .clock     (clock),
      .reset     (reset),
      .pos       (pos),
      .sync      (raw_sync),
      .frame_end (frame_end)
   );

   note_renderer u_notes (
      .clock      (clock),
      .reset      (reset),
      .pos        (pos),
      .note_pixel (note_pixel)
   );

   pattern_generator u_pattern (
      .clock      (clock),
      .reset      (reset),
      .pos        (pos),
      .sync       (raw_sync),
      .note_pixel (note_pixel),
      .mode       (mode_led),
      .pixel      (pixel),
      .sync_out   (sync)
   );

endmodule

`default_nettype wire

// ==== video_timing_pkg.sv ====
// XVGA raster geometry, 1024 x 768 at 60 Hz
// coordinate types for the pixel counters
// packed pixel position and sync/blank bundle
`default_nettype none

package video_timing_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // coordinate types
   ////////////////////////////////////////////////////////////////////////////

   // pixel number within a line, 0 to 1343
   typedef logic [10:0] h_count_t;
   // line number within a frame, 0 to 805
   typedef logic [9:0]  v_count_t;

   typedef struct packed {
      h_count_t hcount;
      v_count_t vcount;
   } pixel_pos_t;

   // both syncs are active low, blank is active high
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic blank;
   } video_sync_t;

   ////////////////////////////////////////////////////////////////////////////
   // line timing, in pixels
   ////////////////////////////////////////////////////////////////////////////
   localparam h_count_t h_active     = 11'd1024;
   localparam h_count_t h_sync_start = 11'd1048;
   localparam h_count_t h_sync_end   = 11'd1184;
   localparam h_count_t h_total      = 11'd1344;

   // frame timing, in lines
   localparam v_count_t v_active     = 10'd768;
   localparam v_count_t v_sync_start = 10'd777;
   localparam v_count_t v_sync_end   = 10'd783;
   localparam v_count_t v_total      = 10'd806;

endpackage

`default_nettype wire

// ==== xvga_timing.sv ====
// XVGA raster counters
// registered hsync, vsync and blank decoded from the package geometry
// single cycle pulse on the last pixel of each frame
`default_nettype none

module xvga_timing (
   input  logic                       clock,
   input  logic                       reset,
   output video_timing_pkg::pixel_pos_t  pos,
   output video_timing_pkg::video_sync_t sync,
   output logic                       frame_end
);

   import video_timing_pkg::*;

   // next raster position, decoded before it is registered
   h_count_t h_next;
   v_count_t v_next;
   logic     h_wrap;
   logic     v_wrap;

   ////////////////////////////////////////////////////////////////////////////
   // next position
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      h_wrap = (pos.hcount == h_total - 1'b1);
      v_wrap = (pos.vcount == v_total - 1'b1);

      // pixel counter runs every cycle
      h_next = h_wrap ? '0 : pos.hcount + 1'b1;

      // line counter steps only at end of line
      v_next = pos.vcount;
      if (h_wrap) begin
         v_next = v_wrap ? '0 : pos.vcount + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // counters and sync register
   // sync and blank are decoded from the next position so they
   // line up with pos on the same clock edge
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         pos.hcount <= '0;
         pos.vcount <= '0;
         // top left pixel is active video, syncs idle
         sync.hsync <= 1'b1;
         sync.vsync <= 1'b1;
         sync.blank <= 1'b0;
         frame_end  <= 1'b0;
      end else begin
         pos.hcount <= h_next;
         pos.vcount <= v_next;

         // active low sync pulses
         sync.hsync <= !((h_next >= h_sync_start) && (h_next < h_sync_end));
         sync.vsync <= !((v_next >= v_sync_start) && (v_next < v_sync_end));

         // outside the visible 1024 x 768 window
         sync.blank <= (h_next >= h_active) || (v_next >= v_active);

         // high while pos sits on pixel (1343, 805)
         frame_end  <= (h_next == h_total - 1'b1) && (v_next == v_total - 1'b1);
      end
   end

endmodule

`default_nettype wire
